// File: source/codec_pkg.sv
package codec_pkg;

  //////////////////////////////////////////////////
  // command and response words
  //////////////////////////////////////////////////
  typedef struct packed {
    logic       rd;    // 1 = register read
    logic [7:0] addr;  // low 7 bits go on the bus
    logic [8:0] data;  // write data, unused on a read
  } codec_cmd_t;

  typedef struct packed {
    logic       done;  // one pulse per finished frame
    logic       nack;  // a byte was not acknowledged
    logic [7:0] rd_data;
  } codec_rsp_t;

  //////////////////////////////////////////////////
  // codec and bus constants
  //////////////////////////////////////////////////
  localparam logic [6:0] CODEC_DEV_ADDR = 7'h1a;
  localparam logic [7:0] ID_REG_ADDR    = 8'h00;
  localparam logic [7:0] ID_VALUE       = 8'h97;

  localparam int INIT_LEN       = 6;
  localparam int CMD_FIFO_DEPTH = 4;
  localparam int SCL_QUARTER    = 4;     // clk cycles per quarter bit
  localparam int FRAME_TIMEOUT  = 2048;  // cycles allowed per response

  // register defaults, written in order after the id check
  localparam codec_cmd_t INIT_TABLE [INIT_LEN] = '{
    '{1'b0, 8'h01, 9'h017},
    '{1'b0, 8'h02, 9'h079},
    '{1'b0, 8'h03, 9'h0d2},
    '{1'b0, 8'h04, 9'h1a0},
    '{1'b0, 8'h05, 9'h012},
    '{1'b0, 8'h06, 9'h100}
  };

  // derived counter widths and end values
  localparam int CMD_PTR_W = $clog2(CMD_FIFO_DEPTH);
  localparam int CMD_CNT_W = $clog2(CMD_FIFO_DEPTH + 1);
  localparam int QTR_CNT_W = $clog2(SCL_QUARTER);
  localparam int TMO_W     = $clog2(FRAME_TIMEOUT + 1);
  localparam int IDX_W     = $clog2(INIT_LEN + 1);

  localparam logic [CMD_PTR_W-1:0] CMD_PTR_LAST = CMD_PTR_W'(CMD_FIFO_DEPTH - 1);
  localparam logic [CMD_CNT_W-1:0] CMD_CREDITS  = CMD_CNT_W'(CMD_FIFO_DEPTH);
  localparam logic [QTR_CNT_W-1:0] QTR_LAST     = QTR_CNT_W'(SCL_QUARTER - 1);
  localparam logic [TMO_W-1:0]     TMO_LAST     = TMO_W'(FRAME_TIMEOUT - 1);
  localparam logic [IDX_W-1:0]     IDX_LAST     = IDX_W'(INIT_LEN - 1);

endpackage

// File: source/codec_init_unit.sv
`timescale 1ns/10ps

module codec_init_unit (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  cmd_push,
  output codec_pkg::codec_cmd_t cmd,
  input  logic                  credit_return,
  input  codec_pkg::codec_rsp_t rsp,
  output logic                  init_done,
  output logic                  init_error
);

  typedef enum logic [2:0] {
    S_ID_RD,
    S_ID_WAIT,
    S_WR_STREAM,
    S_WR_WAIT,
    S_DONE,
    S_ERROR
  } state_t;

  state_t                          state;
  logic [codec_pkg::CMD_CNT_W-1:0] credits;      // free fifo slots
  logic [codec_pkg::IDX_W-1:0]     idx;          // next table entry
  logic [codec_pkg::IDX_W-1:0]     outstanding;  // writes pushed, not yet done
  logic [codec_pkg::TMO_W-1:0]     tmo_cnt;

  logic waiting;
  logic timed_out;
  logic err_now;
  logic push_now;
  logic wr_push;
  logic wr_done;

  //////////////////////////////////////////////////
  // response checks
  //////////////////////////////////////////////////
  assign waiting   = (state == S_ID_WAIT) || (state == S_WR_STREAM) || (state == S_WR_WAIT);
  assign timed_out = waiting && (tmo_cnt == codec_pkg::TMO_LAST);

  // any bad response or a stalled bus ends the sequence
  always_comb begin
    err_now = timed_out;
    if (waiting && rsp.done && rsp.nack) begin
      err_now = 1'b1;
    end
    if (state == S_ID_WAIT && rsp.done && rsp.rd_data != codec_pkg::ID_VALUE) begin
      err_now = 1'b1;
    end
  end

  assign push_now = (credits != '0) && !err_now &&
                    ((state == S_ID_RD) || (state == S_WR_STREAM));
  assign wr_push  = push_now && (state == S_WR_STREAM);
  assign wr_done  = rsp.done && ((state == S_WR_STREAM) || (state == S_WR_WAIT));

  assign init_done  = (state == S_DONE);
  assign init_error = (state == S_ERROR);

  //////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= S_ID_RD;
      credits     <= codec_pkg::CMD_CREDITS;
      idx         <= '0;
      outstanding <= '0;
      tmo_cnt     <= '0;
      cmd_push    <= 1'b0;
    end else begin
      cmd_push <= push_now;

      case ({push_now, credit_return})
        2'b10:   credits <= credits - 1;
        2'b01:   credits <= credits + 1;
        default: credits <= credits;  // none, or one in and one out
      endcase

      case ({wr_push, wr_done})
        2'b10:   outstanding <= outstanding + 1;
        2'b01:   outstanding <= outstanding - 1;
        default: outstanding <= outstanding;
      endcase

      if (wr_push) begin
        idx <= idx + 1;
      end

      // restarts on every response
      if (!waiting || rsp.done) begin
        tmo_cnt <= '0;
      end else begin
        tmo_cnt <= tmo_cnt + 1;
      end

      if (err_now) begin
        state <= S_ERROR;
      end else begin
        case (state)
          S_ID_RD:     if (push_now) state <= S_ID_WAIT;
          S_ID_WAIT:   if (rsp.done) state <= S_WR_STREAM;  // id already matched
          S_WR_STREAM: if (wr_push && idx == codec_pkg::IDX_LAST) state <= S_WR_WAIT;
          S_WR_WAIT:   if (wr_done && outstanding == 1) state <= S_DONE;
          default:     state <= state;  // done and error hold
        endcase
      end
    end
  end

  // command word, loaded with each push
  always_ff @(posedge clk) begin
    if (push_now) begin
      if (state == S_ID_RD) begin
        cmd.rd   <= 1'b1;
        cmd.addr <= codec_pkg::ID_REG_ADDR;
        cmd.data <= '0;
      end else begin
        cmd <= codec_pkg::INIT_TABLE[idx];
      end
    end
  end

endmodule

// File: source/codec_cmd_fifo.sv
`timescale 1ns/10ps

module codec_cmd_fifo (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_push,
  input  codec_pkg::codec_cmd_t cmd,
  output logic                  cmd_valid,
  output codec_pkg::codec_cmd_t cmd_head,
  input  logic                  cmd_pop,
  output logic                  credit_return
);

  codec_pkg::codec_cmd_t mem [codec_pkg::CMD_FIFO_DEPTH];

  logic [codec_pkg::CMD_PTR_W-1:0] wr_ptr;
  logic [codec_pkg::CMD_PTR_W-1:0] rd_ptr;
  logic [codec_pkg::CMD_CNT_W-1:0] count;  // entries held
  logic                            do_pop;

  assign cmd_valid = (count != '0);
  assign cmd_head  = mem[rd_ptr];  // oldest entry
  assign do_pop    = cmd_pop && cmd_valid;

  // one credit back per slot freed
  assign credit_return = do_pop;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////
  // producer holds a credit for every push, so no full check here
  always_ff @(posedge clk) begin
    if (cmd_push) begin
      mem[wr_ptr] <= cmd;
    end
  end

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_push) begin
        wr_ptr <= (wr_ptr == codec_pkg::CMD_PTR_LAST) ? '0 : wr_ptr + 1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == codec_pkg::CMD_PTR_LAST) ? '0 : rd_ptr + 1;
      end

      case ({cmd_push, do_pop})
        2'b10:   count <= count + 1;
        2'b01:   count <= count - 1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: source/codec_i2c_master.sv
`timescale 1ns/10ps

module codec_i2c_master (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_valid,
  input  codec_pkg::codec_cmd_t cmd_head,
  output logic                  cmd_pop,
  output codec_pkg::codec_rsp_t rsp,
  output logic                  scl,
  output logic                  sda_drive_low,
  input  logic                  sda_in
);

  typedef enum logic [2:0] {
    M_IDLE,
    M_START,
    M_SHIFT,    // master sends a byte
    M_ACK,      // slave acknowledge
    M_RSTART,
    M_RSHIFT,   // slave sends a byte
    M_MNACK,
    M_STOP
  } mstate_t;

  mstate_t                         state;
  codec_pkg::codec_cmd_t           cur;       // command in progress
  logic [codec_pkg::QTR_CNT_W-1:0] qcnt;
  logic [1:0]                      phase;     // quarter within the bit
  logic [2:0]                      bit_cnt;
  logic [1:0]                      byte_sel;  // 0 dev wr, 1 reg, 2 data, 3 dev rd
  logic [7:0]                      tx_byte;
  logic [7:0]                      rx_byte;
  logic                            ack_high;  // sampled ack level
  logic                            nack_seen;
  logic                            tick;
  logic                            bit_end;
  logic                            scl_c;
  logic                            sda_low_c;

  function automatic logic [7:0] frame_byte(input logic [1:0] sel,
                                            input codec_pkg::codec_cmd_t c);
    case (sel)
      2'd0:    frame_byte = {codec_pkg::CODEC_DEV_ADDR, 1'b0};
      2'd1:    frame_byte = {c.addr[6:0], c.rd ? 1'b0 : c.data[8]};
      2'd2:    frame_byte = c.data[7:0];
      default: frame_byte = {codec_pkg::CODEC_DEV_ADDR, 1'b1};
    endcase
  endfunction

  assign cmd_pop = (state == M_IDLE) && cmd_valid;

  //////////////////////////////////////////////////
  // quarter-bit divider
  //////////////////////////////////////////////////
  assign tick    = (state != M_IDLE) && (qcnt == codec_pkg::QTR_LAST);
  assign bit_end = tick && (phase == 2'd3);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      qcnt  <= '0;
      phase <= '0;
    end else if (state == M_IDLE) begin
      qcnt  <= '0;
      phase <= '0;
    end else if (tick) begin
      qcnt  <= '0;
      phase <= phase + 1;  // wraps after the fourth quarter
    end else begin
      qcnt <= qcnt + 1;
    end
  end

  //////////////////////////////////////////////////
  // pin levels per phase
  //////////////////////////////////////////////////
  // scl low in quarters 0-1, sda moves only in quarter 1 of a bit,
  // start, repeated start and stop move sda while scl is high
  always_comb begin
    scl_c     = 1'b1;
    sda_low_c = sda_drive_low;  // quarter 0 holds the previous level
    case (state)
      M_IDLE:  sda_low_c = 1'b0;
      M_START: sda_low_c = phase[1];
      M_SHIFT: begin
        scl_c = phase[1];
        if (phase != 2'd0) sda_low_c = ~tx_byte[7];
      end
      M_ACK, M_RSHIFT, M_MNACK: begin
        scl_c = phase[1];
        if (phase != 2'd0) sda_low_c = 1'b0;  // released
      end
      M_RSTART: begin
        scl_c = phase[1];
        if (phase != 2'd0) sda_low_c = (phase == 2'd3);
      end
      default: begin  // stop
        scl_c = phase[1];
        if (phase != 2'd0) sda_low_c = (phase != 2'd3);
      end
    endcase
  end

  //////////////////////////////////////////////////
  // frame sequencer
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state         <= M_IDLE;
      bit_cnt       <= 3'd7;
      byte_sel      <= 2'd0;
      nack_seen     <= 1'b0;
      rsp           <= '0;
      scl           <= 1'b1;
      sda_drive_low <= 1'b0;
    end else begin
      scl           <= scl_c;
      sda_drive_low <= sda_low_c;
      rsp.done      <= 1'b0;
      if (cmd_pop) begin
        state     <= M_START;
        nack_seen <= 1'b0;
      end else if (bit_end) begin
        case (state)
          M_START: begin
            state    <= M_SHIFT;
            byte_sel <= 2'd0;
            bit_cnt  <= 3'd7;
          end
          M_SHIFT:  if (bit_cnt == 3'd0) state <= M_ACK; else bit_cnt <= bit_cnt - 1;
          M_ACK: begin
            bit_cnt <= 3'd7;
            if (ack_high) begin  // no ack, close the frame
              nack_seen <= 1'b1;
              state     <= M_STOP;
            end else begin
              case (byte_sel)
                2'd0: begin
                  byte_sel <= 2'd1;
                  state    <= M_SHIFT;
                end
                2'd1: begin
                  byte_sel <= 2'd2;
                  state    <= cur.rd ? M_RSTART : M_SHIFT;
                end
                2'd2:    state <= M_STOP;
                default: state <= M_RSHIFT;
              endcase
            end
          end
          M_RSTART: begin
            byte_sel <= 2'd3;
            state    <= M_SHIFT;
          end
          M_RSHIFT: if (bit_cnt == 3'd0) state <= M_MNACK; else bit_cnt <= bit_cnt - 1;
          M_MNACK:  state <= M_STOP;
          default: begin  // end of stop
            state       <= M_IDLE;
            rsp.done    <= 1'b1;
            rsp.nack    <= nack_seen;
            rsp.rd_data <= rx_byte;
          end
        endcase
      end
    end
  end

  // shift data, no reset needed
  always_ff @(posedge clk) begin
    if (cmd_pop) cur <= cmd_head;
    if (tick && phase == 2'd2) begin  // scl high and settled
      if (state == M_ACK) ack_high <= sda_in;
      if (state == M_RSHIFT) rx_byte <= {rx_byte[6:0], sda_in};
    end
    if (bit_end) begin
      case (state)
        M_START:  tx_byte <= frame_byte(2'd0, cur);
        M_SHIFT:  tx_byte <= {tx_byte[6:0], 1'b0};  // msb first
        M_ACK:    tx_byte <= frame_byte(byte_sel + 2'd1, cur);
        M_RSTART: tx_byte <= frame_byte(2'd3, cur);
        default:  tx_byte <= tx_byte;
      endcase
    end
  end

endmodule

// File: source/codec_init_top.sv
`timescale 1ns/10ps

module codec_init_top (
  input  logic clk,
  input  logic reset,
  output logic scl,
  output logic sda_drive_low,  // open drain, resolved outside
  input  logic sda_in,
  output logic init_done,
  output logic init_error
);

  codec_pkg::codec_cmd_t cmd;
  codec_pkg::codec_cmd_t cmd_head;
  codec_pkg::codec_rsp_t rsp;
  logic                  cmd_push;
  logic                  cmd_valid;
  logic                  cmd_pop;
  logic                  credit_return;

  //////////////////////////////////////////////////
  // producer, buffer, bus master
  //////////////////////////////////////////////////
  codec_init_unit i_codec_init_unit (
    .clk           (clk),
    .reset         (reset),
    .cmd_push      (cmd_push),
    .cmd           (cmd),
    .credit_return (credit_return),
    .rsp           (rsp),
    .init_done     (init_done),
    .init_error    (init_error)
  );

  codec_cmd_fifo i_codec_cmd_fifo (
    .clk           (clk),
    .reset         (reset),
    .cmd_push      (cmd_push),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .cmd_head      (cmd_head),
    .cmd_pop       (cmd_pop),
    .credit_return (credit_return)
  );

  codec_i2c_master i_codec_i2c_master (
    .clk           (clk),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .cmd_head      (cmd_head),
    .cmd_pop       (cmd_pop),
    .rsp           (rsp),
    .scl           (scl),
    .sda_drive_low (sda_drive_low),
    .sda_in        (sda_in)
  );

endmodule

// File: sim/codec_i2c_model.sv
`timescale 1ns/10ps

module codec_i2c_model (
  input  logic       reset,
  input  logic       scl,
  input  logic       sda_master_low,  // master side of the open-drain line
  input  logic [7:0] id_value,        // returned for the identity register
  input  int         nack_frame,      // write frame to refuse, -1 for none
  output logic       sda_drive_low,
  output logic       busy,
  output int         frame_count,
  output int         wr_count,
  output int         bad_addr,
  output logic       proto_err
);

  logic [8:0] regs [128];
  logic       scl_q, sda_q, sda_m;
  logic       is_read, pend_rd, rd_mode, nacked, d8;
  logic [7:0] sh, rbyte, data_lo;
  logic [6:0] reg_addr;
  int         bitpos, byte_idx;
  int         wr_seen;  // write frames that reached the data byte

  initial begin
    scl_q = 1'b1;
    sda_q = 1'b1;
    proto_err = 1'b0;
    bad_addr = 0;
  end

  always @(scl, sda_master_low, reset) begin
    sda_m = !sda_master_low;
    if (reset) begin
      for (int a = 0; a < 128; a++) regs[a] = {2'b10, 7'(a)};  // address based fill
      sda_drive_low = 1'b0;
      busy = 1'b0;
      frame_count = 0;
      wr_count = 0;
      wr_seen = 0;
      bitpos = 0;
      rd_mode = 1'b0;
    end else if (scl !== scl_q && scl === 1'b1) begin
      ////////////////////////////////////////////////
      // rising scl, sample or close an ack slot
      ////////////////////////////////////////////////
      if (busy && bitpos < 8) begin
        if (!rd_mode) sh = {sh[6:0], sda_m};
        bitpos++;
      end else if (busy) begin
        bitpos = 0;
        byte_idx++;
        if (rd_mode) rd_mode = 1'b0;  // master nack seen
        else if (pend_rd) begin
          rd_mode = 1'b1;
          pend_rd = 1'b0;
        end
      end
    end else if (scl !== scl_q) begin
      // falling scl, the model may move sda
      sda_drive_low = 1'b0;
      if (busy && rd_mode && bitpos < 8) begin
        sda_drive_low = !rbyte[7 - bitpos];
      end else if (busy && !rd_mode && bitpos == 8) begin
        sda_drive_low = 1'b1;
        case (byte_idx)
          0: begin
            if (sh[7:1] != codec_pkg::CODEC_DEV_ADDR) begin
              bad_addr++;
              nacked = 1'b1;
              sda_drive_low = 1'b0;
            end else if (sh[0]) begin
              is_read = 1'b1;
              pend_rd = 1'b1;
              rbyte = (reg_addr == codec_pkg::ID_REG_ADDR[6:0]) ? id_value
                                                                : regs[reg_addr][7:0];
            end
          end
          1: begin
            reg_addr = sh[7:1];
            d8 = sh[0];
          end
          2: begin
            data_lo = sh;
            if (wr_seen == nack_frame) begin  // injected refusal
              nacked = 1'b1;
              sda_drive_low = 1'b0;
            end
            wr_seen++;
          end
          default: sda_drive_low = 1'b0;
        endcase
      end
    end else if (sda_m !== sda_q && scl === 1'b1) begin
      // start and stop are legal only on a bit boundary
      if (busy && bitpos != 1) proto_err = 1'b1;
      if (!sda_m) begin
        if (!busy) begin
          is_read = 1'b0;
          nacked = 1'b0;
          pend_rd = 1'b0;
          rd_mode = 1'b0;
        end
        busy = 1'b1;
        byte_idx = 0;
        bitpos = 0;
      end else begin
        if (!busy) proto_err = 1'b1;
        if (busy && !is_read && !nacked && byte_idx == 3) begin
          regs[reg_addr] = {d8, data_lo};
          wr_count++;
        end
        if (busy) frame_count++;
        busy = 1'b0;
      end
    end
    scl_q = scl;
    sda_q = sda_m;
  end

endmodule

// File: sim/tb_codec_init_top.sv
`timescale 1ns/10ps

module tb_codec_init_top;

  localparam int FRAME_CYCLES = 40 * 4 * codec_pkg::SCL_QUARTER;  // longest frame
  localparam int INIT_LIMIT   = (codec_pkg::INIT_LEN + 2) * FRAME_CYCLES * 2;
  localparam int IDLE_GAP     = FRAME_CYCLES / 4;
  localparam int DRAIN_LIMIT  = (codec_pkg::CMD_FIFO_DEPTH + 2) * FRAME_CYCLES;
  localparam int WR_CYCLES    = 29 * 4 * codec_pkg::SCL_QUARTER;

  logic       clk = 1'b0;
  logic       reset = 1'b1;
  logic       scl, sda_drive_low, sda_in, model_low;
  logic       init_done, init_error, proto_err, model_busy;
  logic [7:0] id_value = codec_pkg::ID_VALUE;
  int         nack_frame = -1;
  int         frame_count, wr_count, bad_addr;
  int         pass_cnt = 0;
  int         fail_cnt = 0;
  bit         test_ok;

  assign sda_in = !(sda_drive_low || model_low);  // open-drain wire

  always #2 clk = ~clk;

  codec_init_top i_codec_init_top (
    .clk (clk), .reset (reset), .scl (scl), .sda_drive_low (sda_drive_low),
    .sda_in (sda_in), .init_done (init_done), .init_error (init_error)
  );

  codec_i2c_model i_codec_i2c_model (
    .reset (reset), .scl (scl), .sda_master_low (sda_drive_low), .id_value (id_value),
    .nack_frame (nack_frame), .sda_drive_low (model_low), .busy (model_busy),
    .frame_count (frame_count), .wr_count (wr_count), .bad_addr (bad_addr),
    .proto_err (proto_err)
  );

  function automatic logic [8:0] fill_value(input logic [7:0] addr);
    fill_value = {2'b10, addr[6:0]};
  endfunction

  task automatic report_timeout(input string why);
    $display("%s", why);
    test_ok = 0;
  endtask

  task automatic expect_eq(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      test_ok = 0;
    end
  endtask

  task automatic end_test(input string name);
    if (test_ok) pass_cnt++;
    else fail_cnt++;
    $display("%s: %s", name, test_ok ? "pass" : "fail");
  endtask

  // reset for two cycles with new model controls
  task automatic start_run(input logic [7:0] id, input int nack_k);
    @(negedge clk);
    reset = 1'b1;
    id_value = id;
    nack_frame = nack_k;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic wait_init();
    int n;
    n = 0;
    while (!init_done && !init_error && n < INIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!init_done && !init_error) begin
      report_timeout("timeout waiting for init_done or init_error");
    end
  endtask

  // queued frames still drain after an error
  task automatic wait_bus_idle();
    int n, quiet;
    n = 0;
    quiet = 0;
    while (quiet < IDLE_GAP && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
      quiet = model_busy ? 0 : quiet + 1;
    end
    if (quiet < IDLE_GAP) report_timeout("timeout waiting for the bus to go idle");
  endtask

  task automatic check_table(input int k, input int stored);
    codec_pkg::codec_cmd_t e;
    for (int i = 0; i < codec_pkg::INIT_LEN; i++) begin
      e = codec_pkg::INIT_TABLE[i];
      if (i != k && (k < 0 || i < k || i <= stored)) begin
        expect_eq(i_codec_i2c_model.regs[e.addr[6:0]], e.data, "register value");
      end else begin
        expect_eq(i_codec_i2c_model.regs[e.addr[6:0]], fill_value(e.addr), "untouched register");
      end
    end
  endtask

  task automatic check_good_run();
    expect_eq(init_done, 1, "init_done");
    expect_eq(init_error, 0, "init_error");
    wait_bus_idle();
    expect_eq(frame_count, 1 + codec_pkg::INIT_LEN, "frame count");
    check_table(-1, codec_pkg::INIT_LEN);
  endtask

  initial begin
    int k, d;
    logic [7:0] bad_id;
    void'($urandom(32'h4c17_b5cd));

    //////////////////////////////////////////////////
    // good identity
    //////////////////////////////////////////////////
    test_ok = 1;
    start_run(codec_pkg::ID_VALUE, -1);
    wait_init();
    check_good_run();
    end_test("good identity");

    // wrong identity
    test_ok = 1;
    bad_id = 8'($urandom);
    if (bad_id == codec_pkg::ID_VALUE) bad_id = ~bad_id;
    start_run(bad_id, -1);
    wait_init();
    expect_eq(init_error, 1, "init_error");
    expect_eq(init_done, 0, "init_done");
    wait_bus_idle();
    expect_eq(wr_count, 0, "write frames");
    end_test("wrong identity");

    // refused write k
    test_ok = 1;
    k = $urandom % codec_pkg::INIT_LEN;
    start_run(codec_pkg::ID_VALUE, k);
    wait_init();
    expect_eq(init_error, 1, "init_error");
    expect_eq(init_done, 0, "init_done");
    wait_bus_idle();
    if (wr_count - k > codec_pkg::CMD_FIFO_DEPTH) begin
      $display("FAILED at %0t ns: %0d writes after the refused one", $time, wr_count - k);
      test_ok = 0;
    end
    check_table(k, wr_count);
    end_test("nack injection");

    //////////////////////////////////////////////////
    // reset during write streaming
    //////////////////////////////////////////////////
    test_ok = 1;
    start_run(codec_pkg::ID_VALUE, -1);
    d = 0;
    while (frame_count < 1 && d < INIT_LIMIT) begin
      @(negedge clk);
      d++;
    end
    if (frame_count < 1) report_timeout("timeout waiting for the identity frame");
    repeat ($urandom % (4 * WR_CYCLES)) @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    expect_eq(scl, 1, "scl in reset");
    expect_eq(sda_drive_low, 0, "sda in reset");
    expect_eq(init_done, 0, "init_done in reset");
    expect_eq(init_error, 0, "init_error in reset");
    start_run(codec_pkg::ID_VALUE, -1);
    wait_init();
    check_good_run();
    end_test("mid-run reset");

    // protocol, over all runs
    test_ok = 1;
    expect_eq(proto_err, 0, "protocol error flag");
    expect_eq(bad_addr, 0, "frames with a foreign address");
    end_test("bus protocol");

    $display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: codec_init_top.f
source/codec_pkg.sv
source/codec_init_unit.sv
source/codec_cmd_fifo.sv
source/codec_i2c_master.sv
source/codec_init_top.sv
sim/codec_i2c_model.sv
sim/tb_codec_init_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the codec init testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_codec_init_top \
  -f codec_init_top.f \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
